// File: hdl/csr_cfg.svh
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

`define CSR_DATA_W      32
`define CSR_NUM_W       14
`define CSR_TIMER_W     32
`define CSR_HWI_W       8

// csr numbers
`define CSR_ADDR_CRMD   14'h000
`define CSR_ADDR_PRMD   14'h001
`define CSR_ADDR_ECFG   14'h004
`define CSR_ADDR_ESTAT  14'h005
`define CSR_ADDR_ERA    14'h006
`define CSR_ADDR_BADV   14'h007
`define CSR_ADDR_EENTRY 14'h00c
`define CSR_ADDR_SAVE0  14'h030
`define CSR_ADDR_TID    14'h040
`define CSR_ADDR_TCFG   14'h041
`define CSR_ADDR_TVAL   14'h042
`define CSR_ADDR_TICLR  14'h044

// write strobe bit positions with save0..3 on bits 7..10
`define CSR_WS_CRMD     0
`define CSR_WS_PRMD     1
`define CSR_WS_ECFG     2
`define CSR_WS_ESTAT    3
`define CSR_WS_ERA      4
`define CSR_WS_BADV     5
`define CSR_WS_EENTRY   6
`define CSR_WS_SAVE0    7
`define CSR_WS_TID      11
`define CSR_WS_TCFG     12
`define CSR_WS_N        13

// lie bit 10 does not exist
`define CSR_ECFG_MASK   13'h1bff
`define CSR_CRMD_RESET  9'h008
`define CSR_ECODE_INT   6'h00

`endif

// File: hdl/csr_pkg.sv
`include "csr_cfg.svh"

package csr_pkg;

    typedef enum logic [2:0] {
        NOP     = 3'd0,
        CSRRD   = 3'd1,
        CSRWR   = 3'd2,
        CSRXCHG = 3'd3,
        EXCP    = 3'd4,
        ERTN    = 3'd5
    } csr_op_e;

    typedef logic [5:0] csr_ecode_t;

    // csr ops read acc, excp ops read exc
    typedef union packed {
        struct packed {
            logic [15-`CSR_NUM_W:0]  pad;
            logic [`CSR_NUM_W-1:0]   num;
        } acc;
        struct packed {
            logic                    pad;
            logic [8:0]              esub;
            csr_ecode_t              ecode;
        } exc;
    } csr_arg_u;

endpackage

// File: hdl/csr_access.sv
`include "csr_cfg.svh"

module csr_access (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          op_valid,
    input  csr_pkg::csr_op_e              op,
    input  csr_pkg::csr_arg_u             op_arg,
    input  logic [`CSR_DATA_W-1:0]        wr_data,
    input  logic [`CSR_DATA_W-1:0]        wr_mask,
    input  logic                          trap_take,
    input  logic [8:0]                    crmd,
    input  logic [2:0]                    prmd,
    input  logic [12:0]                   ecfg_lie,
    input  logic [`CSR_DATA_W-1:0]        estat_word,
    input  logic [`CSR_DATA_W-1:0]        era,
    input  logic [`CSR_DATA_W-1:0]        badv,
    input  logic [`CSR_DATA_W-1:0]        eentry,
    input  logic [3:0][`CSR_DATA_W-1:0]   save,
    input  logic [`CSR_DATA_W-1:0]        tid,
    input  logic [`CSR_TIMER_W-1:0]       tcfg,
    input  logic [`CSR_TIMER_W-1:0]       tval,
    output logic [`CSR_DATA_W-1:0]        rd_data,
    output logic [`CSR_DATA_W-1:0]        wdata,
    output logic [`CSR_WS_N-1:0]          wr_strobe,
    output logic                          ticlr_hit
);
    import csr_pkg::*;

    logic [`CSR_NUM_W-1:0]  csr_num;
    logic [`CSR_DATA_W-1:0] rd_word;
    logic [`CSR_DATA_W-1:0] merge_mask;
    logic [`CSR_WS_N-1:0]   addr_hit;
    logic                   is_write;
    logic                   is_access;

    assign csr_num = op_arg.acc.num;

    always_comb
    begin
        rd_word  = '0;
        addr_hit = '0;
        case (csr_num)
            `CSR_ADDR_CRMD:
            begin
                rd_word = {23'b0, crmd};
                addr_hit[`CSR_WS_CRMD] = 1'b1;
            end
            `CSR_ADDR_PRMD:
            begin
                rd_word = {29'b0, prmd};
                addr_hit[`CSR_WS_PRMD] = 1'b1;
            end
            `CSR_ADDR_ECFG:
            begin
                rd_word = {19'b0, ecfg_lie};
                addr_hit[`CSR_WS_ECFG] = 1'b1;
            end
            `CSR_ADDR_ESTAT:
            begin
                rd_word = estat_word;
                addr_hit[`CSR_WS_ESTAT] = 1'b1;
            end
            `CSR_ADDR_ERA:
            begin
                rd_word = era;
                addr_hit[`CSR_WS_ERA] = 1'b1;
            end
            `CSR_ADDR_BADV:
            begin
                rd_word = badv;
                addr_hit[`CSR_WS_BADV] = 1'b1;
            end
            `CSR_ADDR_EENTRY:
            begin
                rd_word = eentry;
                addr_hit[`CSR_WS_EENTRY] = 1'b1;
            end
            `CSR_ADDR_SAVE0, `CSR_ADDR_SAVE0 + 14'd1,
            `CSR_ADDR_SAVE0 + 14'd2, `CSR_ADDR_SAVE0 + 14'd3:
            begin
                rd_word = save[csr_num[1:0]];
                addr_hit[`CSR_WS_SAVE0 + csr_num[1:0]] = 1'b1;
            end
            `CSR_ADDR_TID:
            begin
                rd_word = tid;
                addr_hit[`CSR_WS_TID] = 1'b1;
            end
            `CSR_ADDR_TCFG:
            begin
                rd_word = tcfg;
                addr_hit[`CSR_WS_TCFG] = 1'b1;
            end
            // tval is read only, ticlr reads as zero
            `CSR_ADDR_TVAL:
                rd_word = tval;
            default:
                rd_word = '0;
        endcase
    end

    assign is_write   = op_valid && !trap_take && (op == CSRWR || op == CSRXCHG);
    assign is_access  = op_valid && !trap_take && (op == CSRRD || is_write);
    assign merge_mask = (op == CSRXCHG) ? wr_mask : '1;
    assign wdata      = (rd_word & ~merge_mask) | (wr_data & merge_mask);
    assign wr_strobe  = is_write ? addr_hit : '0;
    assign ticlr_hit  = is_write && (csr_num == `CSR_ADDR_TICLR) && wdata[0];

    always_ff @(posedge clk)
    begin
        if (!rstn)
            rd_data <= '0;
        else if (is_access)
            rd_data <= rd_word;
    end

endmodule

// File: hdl/csr_state.sv
`include "csr_cfg.svh"

module csr_state (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic [`CSR_DATA_W-1:0]        wdata,
    input  logic [`CSR_WS_N-1:0]          wr_strobe,
    input  logic                          trap_take,
    input  logic                          ertn_take,
    input  csr_pkg::csr_ecode_t           cause_ecode,
    input  logic [8:0]                    cause_esub,
    input  logic [`CSR_DATA_W-1:0]        era_in,
    input  logic [`CSR_DATA_W-1:0]        badv_in,
    input  logic                          badv_we,
    output logic [8:0]                    crmd,
    output logic [2:0]                    prmd,
    output logic [12:0]                   ecfg_lie,
    output logic [1:0]                    estat_is,
    output csr_pkg::csr_ecode_t           estat_ecode,
    output logic [8:0]                    estat_esub,
    output logic [`CSR_DATA_W-1:0]        era,
    output logic [`CSR_DATA_W-1:0]        badv,
    output logic [`CSR_DATA_W-1:0]        eentry,
    output logic [3:0][`CSR_DATA_W-1:0]   save
);

    logic [`CSR_DATA_W-1:6] eentry_q;

    assign eentry = {eentry_q, 6'b0};

    // privilege and cause state
    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            crmd        <= `CSR_CRMD_RESET;
            prmd        <= '0;
            estat_ecode <= '0;
            estat_esub  <= '0;
            era         <= '0;
            badv        <= '0;
        end
        else if (trap_take)
        begin
            prmd        <= crmd[2:0];
            crmd[2:0]   <= 3'b000;
            estat_ecode <= cause_ecode;
            estat_esub  <= cause_esub;
            era         <= era_in;
            if (badv_we)
                badv <= badv_in;
        end
        else if (ertn_take)
        begin
            crmd[2:0] <= prmd;
        end
        else
        begin
            if (wr_strobe[`CSR_WS_CRMD])
                crmd <= wdata[8:0];
            if (wr_strobe[`CSR_WS_PRMD])
                prmd <= wdata[2:0];
            if (wr_strobe[`CSR_WS_ERA])
                era <= wdata;
            if (wr_strobe[`CSR_WS_BADV])
                badv <= wdata;
        end
    end

    // configuration and scratch registers written only by csr ops
    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            ecfg_lie <= '0;
            estat_is <= '0;
            eentry_q <= '0;
            save     <= '0;
        end
        else
        begin
            if (wr_strobe[`CSR_WS_ECFG])
                ecfg_lie <= wdata[12:0] & `CSR_ECFG_MASK;
            // only the two software interrupt bits are writable
            if (wr_strobe[`CSR_WS_ESTAT])
                estat_is <= wdata[1:0];
            if (wr_strobe[`CSR_WS_EENTRY])
                eentry_q <= wdata[`CSR_DATA_W-1:6];
            for (int i = 0; i < 4; i++)
            begin
                if (wr_strobe[`CSR_WS_SAVE0 + i])
                    save[i] <= wdata;
            end
        end
    end

endmodule

// File: hdl/csr_timer.sv
`include "csr_cfg.svh"

module csr_timer (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic [`CSR_DATA_W-1:0]    wdata,
    input  logic [`CSR_WS_N-1:0]      wr_strobe,
    input  logic                      ticlr_hit,
    output logic [`CSR_DATA_W-1:0]    tid,
    output logic [`CSR_TIMER_W-1:0]   tcfg,
    output logic [`CSR_TIMER_W-1:0]   tval,
    output logic                      timer_int
);

    logic                    en_d;
    logic [`CSR_TIMER_W-1:0] init_val;

    // initval field with the two low bits forced to zero
    assign init_val = {tcfg[`CSR_TIMER_W-1:2], 2'b00};

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            tid       <= '0;
            tcfg      <= '0;
            tval      <= '0;
            en_d      <= 1'b0;
            timer_int <= 1'b0;
        end
        else
        begin
            en_d <= tcfg[0];
            if (wr_strobe[`CSR_WS_TID])
                tid <= wdata;
            if (wr_strobe[`CSR_WS_TCFG])
                tcfg <= wdata[`CSR_TIMER_W-1:0];

            // load on enable edge, reload if periodic, stop at all ones
            if (tcfg[0] && !en_d)
                tval <= init_val;
            else if (tcfg[0] && tcfg[1] && tval == '0)
                tval <= init_val;
            else if (tcfg[0] && tval != '1)
                tval <= tval - 1'b1;

            if (ticlr_hit)
                timer_int <= 1'b0;
            else if (tcfg[0] && en_d && tval == '0)
                timer_int <= 1'b1;
        end
    end

endmodule

// File: hdl/csr_trap.sv
`include "csr_cfg.svh"

module csr_trap (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      op_valid,
    input  csr_pkg::csr_op_e          op,
    input  csr_pkg::csr_arg_u         op_arg,
    input  logic [`CSR_DATA_W-1:0]    op_pc,
    input  logic [`CSR_DATA_W-1:0]    op_badv,
    input  logic [`CSR_HWI_W-1:0]     hw_int,
    input  logic                      timer_int,
    input  logic [12:0]               ecfg_lie,
    input  logic [1:0]                estat_is,
    input  logic [8:0]                crmd,
    input  logic [`CSR_DATA_W-1:0]    era,
    input  logic [`CSR_DATA_W-1:0]    eentry,
    output logic                      trap_take,
    output logic                      ertn_take,
    output csr_pkg::csr_ecode_t       cause_ecode,
    output logic [8:0]                cause_esub,
    output logic [`CSR_DATA_W-1:0]    era_in,
    output logic [`CSR_DATA_W-1:0]    badv_in,
    output logic                      badv_we,
    output logic                      redirect_valid,
    output logic [`CSR_DATA_W-1:0]    redirect_pc,
    output logic                      excp_flush,
    output logic                      ertn_flush
);
    import csr_pkg::*;

    logic [12:0] int_pend;
    logic        int_take;
    logic        excp_op;

    // ipi and bit 10 are not implemented
    assign int_pend = {1'b0, timer_int, 1'b0, hw_int, estat_is} & ecfg_lie;
    assign int_take = op_valid && crmd[2] && (|int_pend);
    assign excp_op  = op_valid && !int_take && (op == EXCP);

    assign trap_take   = int_take || excp_op;
    assign ertn_take   = op_valid && !int_take && (op == ERTN);
    assign cause_ecode = int_take ? `CSR_ECODE_INT : op_arg.exc.ecode;
    assign cause_esub  = int_take ? 9'd0 : op_arg.exc.esub;
    assign era_in      = op_pc;
    assign badv_in     = op_badv;
    assign badv_we     = excp_op;

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            redirect_valid <= 1'b0;
            excp_flush     <= 1'b0;
            ertn_flush     <= 1'b0;
        end
        else
        begin
            redirect_valid <= trap_take || ertn_take;
            excp_flush     <= trap_take;
            ertn_flush     <= ertn_take;
        end
    end

    always_ff @(posedge clk)
    begin
        if (trap_take || ertn_take)
            redirect_pc <= trap_take ? eentry : era;
    end

endmodule

// File: hdl/csr_top.sv
`include "csr_cfg.svh"

module csr_top (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      op_valid,
    input  csr_pkg::csr_op_e          op,
    input  csr_pkg::csr_arg_u         op_arg,
    input  logic [`CSR_DATA_W-1:0]    op_pc,
    input  logic [`CSR_DATA_W-1:0]    op_badv,
    input  logic [`CSR_DATA_W-1:0]    wr_data,
    input  logic [`CSR_DATA_W-1:0]    wr_mask,
    input  logic [`CSR_HWI_W-1:0]     hw_int,
    output logic [`CSR_DATA_W-1:0]    rd_data,
    output logic                      redirect_valid,
    output logic [`CSR_DATA_W-1:0]    redirect_pc,
    output logic                      excp_flush,
    output logic                      ertn_flush
);
    import csr_pkg::*;

    logic [`CSR_DATA_W-1:0]        wdata;
    logic [`CSR_WS_N-1:0]          wr_strobe;
    logic                          ticlr_hit;
    logic                          trap_take;
    logic                          ertn_take;
    csr_ecode_t                    cause_ecode;
    logic [8:0]                    cause_esub;
    logic [`CSR_DATA_W-1:0]        era_in;
    logic [`CSR_DATA_W-1:0]        badv_in;
    logic                          badv_we;
    logic [8:0]                    crmd;
    logic [2:0]                    prmd;
    logic [12:0]                   ecfg_lie;
    logic [1:0]                    estat_is;
    csr_ecode_t                    estat_ecode;
    logic [8:0]                    estat_esub;
    logic [`CSR_DATA_W-1:0]        era;
    logic [`CSR_DATA_W-1:0]        badv;
    logic [`CSR_DATA_W-1:0]        eentry;
    logic [3:0][`CSR_DATA_W-1:0]   save;
    logic [`CSR_DATA_W-1:0]        tid;
    logic [`CSR_TIMER_W-1:0]       tcfg;
    logic [`CSR_TIMER_W-1:0]       tval;
    logic                          timer_int;

    csr_access u_access (
        .clk(clk), .rstn(rstn), .op_valid(op_valid), .op(op), .op_arg(op_arg),
        .wr_data(wr_data), .wr_mask(wr_mask), .trap_take(trap_take),
        .crmd(crmd), .prmd(prmd), .ecfg_lie(ecfg_lie),
        // estat fields from esub down to swi
        .estat_word({1'b0, estat_esub, estat_ecode, 4'b0, timer_int, 1'b0, hw_int, estat_is}),
        .era(era), .badv(badv), .eentry(eentry), .save(save),
        .tid(tid), .tcfg(tcfg), .tval(tval),
        .rd_data(rd_data), .wdata(wdata), .wr_strobe(wr_strobe), .ticlr_hit(ticlr_hit)
    );

    csr_state u_state (
        .clk(clk), .rstn(rstn), .wdata(wdata), .wr_strobe(wr_strobe),
        .trap_take(trap_take), .ertn_take(ertn_take),
        .cause_ecode(cause_ecode), .cause_esub(cause_esub),
        .era_in(era_in), .badv_in(badv_in), .badv_we(badv_we),
        .crmd(crmd), .prmd(prmd), .ecfg_lie(ecfg_lie), .estat_is(estat_is),
        .estat_ecode(estat_ecode), .estat_esub(estat_esub),
        .era(era), .badv(badv), .eentry(eentry), .save(save)
    );

    csr_timer u_timer (
        .clk(clk), .rstn(rstn), .wdata(wdata), .wr_strobe(wr_strobe),
        .ticlr_hit(ticlr_hit), .tid(tid), .tcfg(tcfg), .tval(tval),
        .timer_int(timer_int)
    );

    csr_trap u_trap (
        .clk(clk), .rstn(rstn), .op_valid(op_valid), .op(op), .op_arg(op_arg),
        .op_pc(op_pc), .op_badv(op_badv), .hw_int(hw_int), .timer_int(timer_int),
        .ecfg_lie(ecfg_lie), .estat_is(estat_is), .crmd(crmd), .era(era),
        .eentry(eentry), .trap_take(trap_take), .ertn_take(ertn_take),
        .cause_ecode(cause_ecode), .cause_esub(cause_esub), .era_in(era_in),
        .badv_in(badv_in), .badv_we(badv_we), .redirect_valid(redirect_valid),
        .redirect_pc(redirect_pc), .excp_flush(excp_flush), .ertn_flush(ertn_flush)
    );

endmodule

// File: sim/csr_sva.sv
module csr_sva (
    input logic clk,
    input logic rstn,
    input logic redirect_valid,
    input logic excp_flush,
    input logic ertn_flush
);
    timeunit 1ns;
    timeprecision 1ps;

    flush_exclusive: assert property (@(posedge clk) disable iff (!rstn)
        !(excp_flush && ertn_flush))
        else $error("excp_flush and ertn_flush high together");

    flush_redirect: assert property (@(posedge clk) disable iff (!rstn)
        (excp_flush || ertn_flush) |-> redirect_valid)
        else $error("flush without redirect_valid");

    // flushes clear on the edge that samples reset
    flush_reset: assert property (@(posedge clk)
        !rstn |=> !(excp_flush || ertn_flush))
        else $error("flush high during reset");

    excp_pulse: assert property (@(posedge clk) disable iff (!rstn)
        excp_flush |=> !excp_flush)
        else $error("excp_flush longer than one cycle");

    ertn_pulse: assert property (@(posedge clk) disable iff (!rstn)
        ertn_flush |=> !ertn_flush)
        else $error("ertn_flush longer than one cycle");

endmodule

// File: sim/csr_tb.sv
`include "csr_cfg.svh"

module csr_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import csr_pkg::*;

    localparam int clk_half   = 20;
    localparam int timer_init = 5;
    // ops issued by all tests plus the timer countdown
    localparam int run_cycles = 80 + timer_init * 4;

    logic                  clk, rstn, op_valid;
    csr_op_e               op;
    csr_arg_u              op_arg;
    logic [31:0]           op_pc, op_badv, wr_data, wr_mask, rd_data, redirect_pc;
    logic [`CSR_HWI_W-1:0] hw_int;
    logic                  redirect_valid, excp_flush, ertn_flush;
    logic [31:0]           got_rd, got_pc, lcg_state, eentry_exp, trap_pc;
    logic                  got_redir, got_excp, got_ertn;
    logic [31:0]           save_exp [4];
    int                    n_checks, n_errors;

    csr_top DUT (.*);

    bind csr_top csr_sva u_sva (
        .clk(clk), .rstn(rstn), .redirect_valid(redirect_valid),
        .excp_flush(excp_flush), .ertn_flush(ertn_flush)
    );

    always #clk_half clk = ~clk;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic csr_arg_u acc_arg(input logic [`CSR_NUM_W-1:0] num);
        csr_arg_u a;
        a = '0;
        a.acc.num = num;
        return a;
    endfunction

    function automatic csr_arg_u exc_arg(input csr_ecode_t ecode, input logic [8:0] esub);
        csr_arg_u a;
        a = '0;
        a.exc.ecode = ecode;
        a.exc.esub = esub;
        return a;
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        n_checks++;
        if (act !== exp)
        begin
            n_errors++;
            $display("ERR %s: expected %08h, actual %08h", name, exp, act);
        end
    endtask

    // one op per cycle, results sampled at the following falling edge
    task automatic do_op(input csr_op_e cmd, input csr_arg_u arg, input logic [31:0] data,
                         input logic [31:0] mask, input logic [31:0] pc,
                         input logic [31:0] badv);
        op_valid = 1'b1;
        op       = cmd;
        op_arg   = arg;
        wr_data  = data;
        wr_mask  = mask;
        op_pc    = pc;
        op_badv  = badv;
        @(posedge clk);
        @(negedge clk);
        got_rd    = rd_data;
        got_pc    = redirect_pc;
        got_redir = redirect_valid;
        got_excp  = excp_flush;
        got_ertn  = ertn_flush;
        op_valid  = 1'b0;
    endtask

    task automatic csr_read(input logic [`CSR_NUM_W-1:0] num);
        do_op(CSRRD, acc_arg(num), '0, '0, '0, '0);
    endtask

    task automatic csr_write(input logic [`CSR_NUM_W-1:0] num, input logic [31:0] data);
        do_op(CSRWR, acc_arg(num), data, '0, '0, '0);
    endtask

    // redirect_valid goes with either flush
    task automatic expect_flush(input string name, input logic excp, input logic ertn);
        check({name, " flush"}, {29'b0, excp | ertn, excp, ertn},
              {29'b0, got_redir, got_excp, got_ertn});
    endtask

    task automatic test_reset();
        csr_read(`CSR_ADDR_CRMD);
        check("test_reset crmd", {23'b0, `CSR_CRMD_RESET}, got_rd);
        expect_flush("test_reset", 1'b0, 1'b0);
        csr_read(`CSR_ADDR_ERA);
        check("test_reset era", '0, got_rd);
        csr_read(`CSR_ADDR_ESTAT);
        check("test_reset estat", '0, got_rd);
        csr_read(`CSR_ADDR_SAVE0);
        check("test_reset save0", '0, got_rd);
        expect_flush("test_reset", 1'b0, 1'b0);
    endtask

    task automatic test_rw();
        logic [31:0] w;
        logic [31:0] m;
        for (int i = 0; i < 4; i++)
        begin
            w = next_rand();
            csr_write(`CSR_ADDR_SAVE0 + 14'(i), w);
            check("test_rw save old", save_exp[i], got_rd);
            save_exp[i] = w;
        end
        for (int i = 0; i < 4; i++)
        begin
            csr_read(`CSR_ADDR_SAVE0 + 14'(i));
            check("test_rw save new", save_exp[i], got_rd);
        end
        w = next_rand();
        csr_write(`CSR_ADDR_ERA, w);
        check("test_rw era old", '0, got_rd);
        csr_read(`CSR_ADDR_ERA);
        check("test_rw era new", w, got_rd);
        w = next_rand();
        m = next_rand();
        do_op(CSRXCHG, acc_arg(`CSR_ADDR_SAVE0 + 14'd1), w, m, '0, '0);
        check("test_rw xchg old", save_exp[1], got_rd);
        save_exp[1] = (save_exp[1] & ~m) | (w & m);
        csr_read(`CSR_ADDR_SAVE0 + 14'd1);
        check("test_rw xchg merged", save_exp[1], got_rd);
        // lie has bits 12, 11 and 9..0 only
        w = next_rand();
        csr_write(`CSR_ADDR_ECFG, w);
        csr_read(`CSR_ADDR_ECFG);
        check("test_rw ecfg", w & 32'h0000_1bff, got_rd);
        csr_write(`CSR_ADDR_ECFG, '0);
    endtask

    task automatic test_exception();
        logic [31:0] badv_w;
        csr_write(`CSR_ADDR_CRMD, 32'h0000_000f);
        eentry_exp = next_rand();
        csr_write(`CSR_ADDR_EENTRY, eentry_exp);
        eentry_exp = eentry_exp & 32'hffff_ffc0;
        trap_pc = next_rand();
        badv_w  = next_rand();
        do_op(EXCP, exc_arg(6'h0b, 9'h055), '0, '0, trap_pc, badv_w);
        expect_flush("test_exception", 1'b1, 1'b0);
        check("test_exception redirect", eentry_exp, got_pc);
        csr_read(`CSR_ADDR_ERA);
        check("test_exception era", trap_pc, got_rd);
        csr_read(`CSR_ADDR_BADV);
        check("test_exception badv", badv_w, got_rd);
        // esubcode at 30..22, ecode at 21..16
        csr_read(`CSR_ADDR_ESTAT);
        check("test_exception estat", {1'b0, 9'h055, 6'h0b, 16'h0}, got_rd);
        csr_read(`CSR_ADDR_PRMD);
        check("test_exception prmd", 32'h7, got_rd);
        csr_read(`CSR_ADDR_CRMD);
        check("test_exception crmd", 32'h0, got_rd & 32'h7);
    endtask

    task automatic test_ertn();
        do_op(ERTN, acc_arg('0), '0, '0, '0, '0);
        expect_flush("test_ertn", 1'b0, 1'b1);
        check("test_ertn redirect", trap_pc, got_pc);
        csr_read(`CSR_ADDR_CRMD);
        check("test_ertn crmd", 32'h7, got_rd & 32'h7);
    endtask

    task automatic test_timer();
        logic [31:0] pc;
        csr_write(`CSR_ADDR_TCFG, {30'(timer_init), 2'b01});
        csr_read(`CSR_ADDR_ESTAT);
        while (!got_rd[11])
            csr_read(`CSR_ADDR_ESTAT);
        csr_write(`CSR_ADDR_ECFG, 32'h0000_0800);
        pc = next_rand();
        do_op(NOP, acc_arg('0), '0, '0, pc, '0);
        expect_flush("test_timer", 1'b1, 1'b0);
        check("test_timer redirect", eentry_exp, got_pc);
        csr_read(`CSR_ADDR_ERA);
        check("test_timer era", pc, got_rd);
        csr_read(`CSR_ADDR_ESTAT);
        check("test_timer estat", 32'h0000_0800, got_rd);
        csr_write(`CSR_ADDR_TICLR, 32'h1);
        check("test_timer ticlr read", '0, got_rd);
        csr_read(`CSR_ADDR_ESTAT);
        check("test_timer cleared", '0, got_rd);
        csr_write(`CSR_ADDR_TCFG, '0);
        csr_write(`CSR_ADDR_ECFG, '0);
    endtask

    task automatic test_hw_int();
        logic [31:0] w;
        logic [31:0] pc;
        csr_write(`CSR_ADDR_CRMD, 32'h0000_000c);
        // hw_int[2] sits at estat bit 4
        csr_write(`CSR_ADDR_ECFG, 32'h0000_0010);
        hw_int = 8'h04;
        w  = next_rand();
        pc = next_rand();
        do_op(CSRWR, acc_arg(`CSR_ADDR_SAVE0 + 14'd2), w, '0, pc, '0);
        expect_flush("test_hw_int taken", 1'b1, 1'b0);
        csr_read(`CSR_ADDR_SAVE0 + 14'd2);
        check("test_hw_int save kept", save_exp[2], got_rd);
        csr_read(`CSR_ADDR_ERA);
        check("test_hw_int era", pc, got_rd);
        csr_read(`CSR_ADDR_ESTAT);
        check("test_hw_int estat", 32'h0000_0010, got_rd);
        csr_write(`CSR_ADDR_ECFG, '0);
        csr_write(`CSR_ADDR_CRMD, 32'h0000_000c);
        do_op(CSRWR, acc_arg(`CSR_ADDR_SAVE0 + 14'd2), w, '0, pc, '0);
        expect_flush("test_hw_int masked", 1'b0, 1'b0);
        check("test_hw_int old", save_exp[2], got_rd);
        save_exp[2] = w;
        csr_read(`CSR_ADDR_SAVE0 + 14'd2);
        check("test_hw_int save new", save_exp[2], got_rd);
        hw_int = '0;
    endtask

    initial
    begin
        #(run_cycles * 4 * clk_half);
        $display("timeout: tests did not finish within %0d ns", run_cycles * 4 * clk_half);
        $display("*** FAILED ***");
        $finish;
    end

    initial
    begin
        clk        = 1'b0;
        rstn       = 1'b0;
        op_valid   = 1'b0;
        op         = NOP;
        op_arg     = '0;
        op_pc      = '0;
        op_badv    = '0;
        wr_data    = '0;
        wr_mask    = '0;
        hw_int     = '0;
        lcg_state  = 32'd63168;
        eentry_exp = '0;
        trap_pc    = '0;
        n_checks   = 0;
        n_errors   = 0;
        foreach (save_exp[i])
            save_exp[i] = '0;
        repeat (3) @(negedge clk);
        rstn = 1'b1;
        check("test_reset rd_data", '0, rd_data);
        test_reset();
        test_rw();
        test_exception();
        test_ertn();
        test_timer();
        test_hw_int();
        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+hdl
hdl/csr_pkg.sv
hdl/csr_access.sv
hdl/csr_state.sv
hdl/csr_timer.sv
hdl/csr_trap.sv
hdl/csr_top.sv
sim/csr_sva.sv
sim/csr_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the CSR unit simulation with Verilator.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --timescale 1ns/1ps -Wno-fatal \
    -f filelist.f --top-module csr_tb -o csr_sim

./obj_dir/csr_sim > sim.log 2>&1 || true
cat sim.log

if grep -qF "*** PASSED ***" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
